/* flist.f */
qs_pkg.sv
qs_in.sv
qs_sorter.sv
qs_out.sv
qs.sv
tb_qs.sv

/* qs.sv */
`timescale 1ns/1ns
`default_nettype none

module qs (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              in_vld,
  input  logic              in_sop,
  input  logic              in_eop,
  input  qs_pkg::w_t        in_dat,
  output logic              in_rdy,
  output logic              out_vld_r,
  output logic              out_sop_r,
  output logic              out_eop_r,
  output logic              out_err_r,
  output qs_pkg::w_t        out_dat_r
);

  // Buffer write path from the input side
  logic          wr_en;
  qs_pkg::addr_t wr_addr;
  qs_pkg::w_t    wr_dat;

  // Handover of a stored packet to the sorter
  logic          load_done;
  qs_pkg::len_t  load_len;
  logic          load_err;
  logic          busy;

  // Handover of the sorted buffer to the output side
  logic          unload_start;
  qs_pkg::len_t  unload_len;
  logic          unload_err;
  logic          unload_done;
  logic          rd_en;
  qs_pkg::addr_t rd_addr;
  qs_pkg::w_t    rd_dat;

  qs_in i_qs_in (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_vld    (in_vld),
    .in_sop    (in_sop),
    .in_eop    (in_eop),
    .in_dat    (in_dat),
    .busy      (busy),
    .in_rdy    (in_rdy),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_dat    (wr_dat),
    .load_done (load_done),
    .load_len  (load_len),
    .load_err  (load_err)
  );

  qs_sorter i_qs_sorter (
    .clk          (clk),
    .arst_n       (arst_n),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_dat       (wr_dat),
    .load_done    (load_done),
    .load_len     (load_len),
    .load_err     (load_err),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .unload_done  (unload_done),
    .busy         (busy),
    .unload_start (unload_start),
    .unload_len   (unload_len),
    .unload_err   (unload_err),
    .rd_dat       (rd_dat)
  );

  qs_out i_qs_out (
    .clk          (clk),
    .arst_n       (arst_n),
    .unload_start (unload_start),
    .unload_len   (unload_len),
    .unload_err   (unload_err),
    .rd_dat       (rd_dat),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .unload_done  (unload_done),
    .out_vld_r    (out_vld_r),
    .out_sop_r    (out_sop_r),
    .out_eop_r    (out_eop_r),
    .out_err_r    (out_err_r),
    .out_dat_r    (out_dat_r)
  );

endmodule

`default_nettype wire

/* qs_in.sv */
`timescale 1ns/1ns
`default_nettype none

module qs_in (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              in_vld,
  input  logic              in_sop,
  input  logic              in_eop,
  input  qs_pkg::w_t        in_dat,
  input  logic              busy,
  output logic              in_rdy,
  output logic              wr_en,
  output qs_pkg::addr_t     wr_addr,
  output qs_pkg::w_t        wr_dat,
  output logic              load_done,
  output qs_pkg::len_t      load_len,
  output logic              load_err
);

  // A packet has started and its eop has not been seen yet
  logic          open_r;
  // Words taken so far, held at N once the buffer is full
  qs_pkg::len_t  idx_r;
  // Sticky oversize flag of the open packet
  logic          ovf_r;
  logic          rdy_r;

  logic          take;
  logic          in_pkt;
  qs_pkg::len_t  cur_idx;
  logic          cur_full;
  logic          cur_ovf;
  qs_pkg::len_t  nxt_idx;

  assign in_rdy = rdy_r;
  assign take   = in_vld & rdy_r;

  // Beats outside a packet are taken off the bus but go nowhere
  assign in_pkt = take & (in_sop | open_r);

  // A sop always restarts the index, even inside an open packet
  assign cur_idx  = in_sop ? '0 : idx_r;
  assign cur_full = (cur_idx == qs_pkg::LW'(qs_pkg::N));
  assign cur_ovf  = (in_sop ? 1'b0 : ovf_r) | cur_full;
  assign nxt_idx  = cur_full ? cur_idx : cur_idx + qs_pkg::len_t'(1);

  // Words past the buffer depth are dropped here
  assign wr_en   = in_pkt & ~cur_full;
  assign wr_addr = qs_pkg::addr_t'(cur_idx);
  assign wr_dat  = in_dat;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      open_r    <= 1'b0;
      idx_r     <= '0;
      ovf_r     <= 1'b0;
      rdy_r     <= 1'b0;
      load_done <= 1'b0;
    end else begin
      load_done <= 1'b0;
      // Stop taking beats right after eop, then wait for the sorter to drain
      if (in_pkt && in_eop) begin
        rdy_r <= 1'b0;
      end else begin
        rdy_r <= ~busy;
      end
      if (in_pkt) begin
        open_r <= ~in_eop;
        idx_r  <= nxt_idx;
        ovf_r  <= cur_ovf;
        // The saturated count is exactly the number of stored words
        load_done <= in_eop;
      end
    end
  end

  // Length and error only matter in the cycle of load_done
  always_ff @(posedge clk) begin
    if (in_pkt && in_eop) begin
      load_len <= nxt_idx;
      load_err <= cur_ovf;
    end
  end

  // The sorter owns the buffer while busy, so no write may reach it
  a_no_wr_busy : assert property (@(posedge clk) disable iff (!arst_n)
    busy |-> !wr_en);

endmodule

`default_nettype wire

/* qs_out.sv */
`timescale 1ns/1ns
`default_nettype none

module qs_out (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              unload_start,
  input  qs_pkg::len_t      unload_len,
  input  logic              unload_err,
  input  qs_pkg::w_t        rd_dat,
  output logic              rd_en,
  output qs_pkg::addr_t     rd_addr,
  output logic              unload_done,
  output logic              out_vld_r,
  output logic              out_sop_r,
  output logic              out_eop_r,
  output logic              out_err_r,
  output qs_pkg::w_t        out_dat_r
);

  logic          run_r;
  // Next read address, back at zero between packets
  qs_pkg::addr_t addr_r;
  qs_pkg::len_t  len_r;
  logic          err_r;

  // Markers of the read in flight, aligned with rd_dat
  logic          s1_vld_r;
  logic          s1_sop_r;
  logic          s1_eop_r;
  logic          s1_err_r;

  qs_pkg::len_t  cur_len;
  qs_pkg::addr_t last_addr;
  logic          rd_last;

  // The first read goes out in the unload_start cycle itself
  assign rd_en   = unload_start | run_r;
  assign rd_addr = addr_r;

  assign cur_len   = run_r ? len_r : unload_len;
  assign last_addr = qs_pkg::addr_t'(cur_len - qs_pkg::len_t'(1));
  assign rd_last   = rd_en & (addr_r == last_addr);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run_r       <= 1'b0;
      addr_r      <= '0;
      s1_vld_r    <= 1'b0;
      s1_sop_r    <= 1'b0;
      s1_eop_r    <= 1'b0;
      s1_err_r    <= 1'b0;
      unload_done <= 1'b0;
      out_vld_r   <= 1'b0;
      out_sop_r   <= 1'b0;
      out_eop_r   <= 1'b0;
      out_err_r   <= 1'b0;
    end else begin
      if (rd_en) begin
        run_r  <= ~rd_last;
        addr_r <= rd_last ? '0 : addr_r + 1'b1;
      end
      s1_vld_r    <= rd_en;
      s1_sop_r    <= unload_start;
      s1_eop_r    <= rd_last;
      s1_err_r    <= rd_en & (unload_start ? unload_err : err_r);
      // The sorter leaves UNLOAD once the last read has been served
      unload_done <= rd_last;
      out_vld_r   <= s1_vld_r;
      out_sop_r   <= s1_sop_r;
      out_eop_r   <= s1_eop_r;
      out_err_r   <= s1_err_r;
    end
  end

  always_ff @(posedge clk) begin
    if (unload_start) begin
      len_r <= unload_len;
      err_r <= unload_err;
    end
    out_dat_r <= rd_dat;
  end

  // A packet starts with both flags rising in the same cycle
  a_sop_vld : assert property (@(posedge clk) disable iff (!arst_n)
    ($rose(out_vld_r) || $rose(out_sop_r)) |-> (out_vld_r && out_sop_r));

endmodule

`default_nettype wire

/* qs_pkg.sv */
`default_nettype none

package qs_pkg;

  // Width of one key word on the stream and in the sort buffer
  localparam int W = 16;

  // Buffer depth, the largest packet that sorts without the error flag
  localparam int N = 16;

  // Index width into the buffer and the stack
  localparam int AW = $clog2(N);

  // Count width, one bit wider so that a full buffer of N words fits
  localparam int LW = $clog2(N + 1);

  // Key as stored and compared, always unsigned
  typedef logic [W-1:0] w_t;

  // Position of a word inside the buffer
  typedef logic [AW-1:0] addr_t;

  // Number of words in a packet or on the stack
  typedef logic [LW-1:0] len_t;

  // Phases of the sorter.
  // LOAD sets up the full range once the packet is stored.
  // PIVOT, SCAN, SWAP and PLACE run one Lomuto partition.
  // POP takes the next subrange off the stack
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    PIVOT,
    SCAN,
    SWAP,
    PLACE,
    POP,
    UNLOAD
  } qs_state_t;

endpackage

`default_nettype wire

/* qs_sorter.sv */
`timescale 1ns/1ns
`default_nettype none

module qs_sorter (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              wr_en,
  input  qs_pkg::addr_t     wr_addr,
  input  qs_pkg::w_t        wr_dat,
  input  logic              load_done,
  input  qs_pkg::len_t      load_len,
  input  logic              load_err,
  input  logic              rd_en,
  input  qs_pkg::addr_t     rd_addr,
  input  logic              unload_done,
  output logic              busy,
  output logic              unload_start,
  output qs_pkg::len_t      unload_len,
  output logic              unload_err,
  output qs_pkg::w_t        rd_dat
);

  // Sort buffer, sorted in place
  qs_pkg::w_t        mem    [qs_pkg::N];
  // Pending subranges, lo and hi index of each
  qs_pkg::addr_t     stk_lo [qs_pkg::N];
  qs_pkg::addr_t     stk_hi [qs_pkg::N];

  qs_pkg::qs_state_t state_r;
  // Number of entries on the stack
  qs_pkg::len_t      sp_r;
  // Bounds of the range being partitioned
  qs_pkg::addr_t     lo_r;
  qs_pkg::addr_t     hi_r;
  // Lomuto store index and scan index
  qs_pkg::addr_t     i_r;
  qs_pkg::addr_t     j_r;
  qs_pkg::w_t        pivot_r;
  qs_pkg::len_t      len_r;
  logic              err_r;
  logic              start_r;

  logic              push_l;
  logic              push_r;
  qs_pkg::len_t      push_cnt;
  qs_pkg::addr_t     push_l_idx;
  qs_pkg::addr_t     push_r_idx;
  qs_pkg::addr_t     pop_idx;
  logic              less;

  // load_done counts as busy so that in_rdy stays low without a gap
  assign busy         = load_done | (state_r != qs_pkg::IDLE);
  assign unload_start = start_r;
  assign unload_len   = len_r;
  assign unload_err   = err_r;

  assign less = (mem[j_r] < pivot_r);

  // After PLACE the pivot sits at i_r, the two sides are lo..i-1 and i+1..hi
  assign push_l   = (qs_pkg::len_t'(i_r) - qs_pkg::len_t'(lo_r)) >= qs_pkg::len_t'(2);
  assign push_r   = (qs_pkg::len_t'(hi_r) - qs_pkg::len_t'(i_r)) >= qs_pkg::len_t'(2);
  assign push_cnt = qs_pkg::len_t'(push_l) + qs_pkg::len_t'(push_r);

  // Left side goes first so that the right side is popped next
  assign push_l_idx = qs_pkg::addr_t'(sp_r);
  assign push_r_idx = qs_pkg::addr_t'(sp_r + qs_pkg::len_t'(push_l));
  assign pop_idx    = qs_pkg::addr_t'(sp_r - qs_pkg::len_t'(1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_r <= qs_pkg::IDLE;
      sp_r    <= '0;
      lo_r    <= '0;
      hi_r    <= '0;
      i_r     <= '0;
      j_r     <= '0;
      start_r <= 1'b0;
    end else begin
      start_r <= 1'b0;
      case (state_r)
        qs_pkg::IDLE: begin
          if (load_done) begin
            state_r <= qs_pkg::LOAD;
          end
        end
        qs_pkg::LOAD: begin
          // Fewer than two words are sorted already
          if (len_r < qs_pkg::len_t'(2)) begin
            state_r <= qs_pkg::UNLOAD;
            start_r <= 1'b1;
          end else begin
            lo_r    <= '0;
            hi_r    <= qs_pkg::addr_t'(len_r - qs_pkg::len_t'(1));
            state_r <= qs_pkg::PIVOT;
          end
        end
        qs_pkg::PIVOT: begin
          i_r     <= lo_r;
          j_r     <= lo_r;
          state_r <= qs_pkg::SCAN;
        end
        qs_pkg::SCAN: begin
          if (j_r == hi_r) begin
            state_r <= qs_pkg::PLACE;
          end else if (less) begin
            state_r <= qs_pkg::SWAP;
          end else begin
            j_r <= j_r + 1'b1;
          end
        end
        qs_pkg::SWAP: begin
          // Word j moved below the store index, both advance
          i_r     <= i_r + 1'b1;
          j_r     <= j_r + 1'b1;
          state_r <= qs_pkg::SCAN;
        end
        qs_pkg::PLACE: begin
          sp_r    <= sp_r + push_cnt;
          state_r <= qs_pkg::POP;
        end
        qs_pkg::POP: begin
          if (sp_r == '0) begin
            state_r <= qs_pkg::UNLOAD;
            start_r <= 1'b1;
          end else begin
            lo_r    <= stk_lo[pop_idx];
            hi_r    <= stk_hi[pop_idx];
            sp_r    <= sp_r - qs_pkg::len_t'(1);
            state_r <= qs_pkg::PIVOT;
          end
        end
        qs_pkg::UNLOAD: begin
          if (unload_done) begin
            state_r <= qs_pkg::IDLE;
          end
        end
        default: begin
          state_r <= qs_pkg::IDLE;
        end
      endcase
    end
  end

  // Packet attributes, taken once per packet
  always_ff @(posedge clk) begin
    if (state_r == qs_pkg::IDLE && load_done) begin
      len_r <= load_len;
      err_r <= load_err;
    end
    // The last word of the range is the pivot
    if (state_r == qs_pkg::PIVOT) begin
      pivot_r <= mem[hi_r];
    end
  end

  // Input writes only happen in IDLE, so they never meet a swap
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_dat;
    end else if (state_r == qs_pkg::SWAP) begin
      mem[i_r] <= mem[j_r];
      mem[j_r] <= mem[i_r];
    end else if (state_r == qs_pkg::PLACE) begin
      mem[i_r] <= pivot_r;
      mem[hi_r] <= mem[i_r];
    end
  end

  always_ff @(posedge clk) begin
    if (state_r == qs_pkg::PLACE && push_l) begin
      stk_lo[push_l_idx] <= lo_r;
      stk_hi[push_l_idx] <= i_r - 1'b1;
    end
    if (state_r == qs_pkg::PLACE && push_r) begin
      stk_lo[push_r_idx] <= i_r + 1'b1;
      stk_hi[push_r_idx] <= hi_r;
    end
  end

  // Registered read port for the output side
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_dat <= mem[rd_addr];
    end
  end

  a_stk_ovf : assert property (@(posedge clk) disable iff (!arst_n)
    (state_r == qs_pkg::PLACE) |-> (int'(sp_r) + int'(push_cnt) <= qs_pkg::N));

  // The output side may only read once the sort has finished
  a_rd_unload : assert property (@(posedge clk) disable iff (!arst_n)
    rd_en |-> (state_r == qs_pkg::UNLOAD));

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal -f flist.f --top-module tb_qs -o tb_qs

./obj_dir/tb_qs | tee sim.log

if grep -qx "sim passed" sim.log; then
  exit 0
else
  echo "run.sh: pass message not found in sim.log"
  exit 1
fi

/* tb_qs.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_qs;

  localparam int MAXLEN  = qs_pkg::N + 3;
  localparam int NT      = 13;
  localparam int TIMEOUT = 4000;

  typedef enum int {M_RAND, M_ASC, M_DESC, M_EQUAL, M_CONST} mode_t;

  logic       clk;
  logic       arst_n;
  logic       in_vld;
  logic       in_sop;
  logic       in_eop;
  qs_pkg::w_t in_dat;
  logic       in_rdy;
  logic       out_vld_r;
  logic       out_sop_r;
  logic       out_eop_r;
  logic       out_err_r;
  qs_pkg::w_t out_dat_r;

  // One row per packet: name, length, data mode and the gap flag
  // Gap rows also send stray beats without sop ahead of the packet
  string t_name [NT] = '{"rand_2", "rand_5", "rand_9_gaps", "rand_16", "ascending",
                         "descending", "all_equal", "single", "oversize", "after_oversize",
                         "const_gaps", "rand_3_gaps", "rand_16_gaps"};
  int    t_len  [NT] = '{2, 5, 9, 16, 16, 16, 12, 1, MAXLEN, 7, 16, 3, 16};
  mode_t t_mode [NT] = '{M_RAND, M_RAND, M_RAND, M_RAND, M_ASC, M_DESC, M_EQUAL, M_RAND,
                         M_CONST, M_RAND, M_CONST, M_RAND, M_RAND};
  bit    t_gap  [NT] = '{0, 0, 1, 0, 0, 0, 0, 0, 0, 1, 1, 1, 1};

  // Fixed words with duplicates and both extremes of the key range
  qs_pkg::w_t const_w [MAXLEN] = '{16'h0042, 16'hffff, 16'h0000, 16'h1234, 16'h0042,
                                   16'h8000, 16'h7fff, 16'h0001, 16'hbeef, 16'h0042,
                                   16'hfffe, 16'h0100, 16'h00ff, 16'hc0de, 16'h0000,
                                   16'h5a5a, 16'h0003, 16'h0002, 16'h0001};

  qs_pkg::w_t  pkt   [MAXLEN];
  qs_pkg::w_t  exp_w [qs_pkg::N];
  logic [31:0] lfsr_q;
  int          err_cnt;
  bit          hung;

  qs i_qs (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_vld    (in_vld),
    .in_sop    (in_sop),
    .in_eop    (in_eop),
    .in_dat    (in_dat),
    .in_rdy    (in_rdy),
    .out_vld_r (out_vld_r),
    .out_sop_r (out_sop_r),
    .out_eop_r (out_eop_r),
    .out_err_r (out_err_r),
    .out_dat_r (out_dat_r)
  );

  always #20 clk = ~clk;

  task check_value(input string name, input string what, input int expv, input int actv);
    assert (expv == actv) else begin
      $display("error %s %s: expected %0h, actual %0h", name, what, expv, actv);
      err_cnt++;
    end
  endtask

  // Galois LFSR step for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // Galois LFSR, one step per bit of the word
  task draw_word(output qs_pkg::w_t word);
    int b;
    for (b = 0; b < qs_pkg::W; b++) begin
      word[b] = lfsr_q[0];
      lfsr_q  = lfsr_next(lfsr_q);
    end
  endtask

  task build_packet(input int t);
    int k;
    for (k = 0; k < t_len[t]; k++) begin
      case (t_mode[t])
        M_RAND:  draw_word(pkt[k]);
        M_ASC:   pkt[k] = qs_pkg::w_t'(k * 32'h0111 + 3);
        M_DESC:  pkt[k] = qs_pkg::w_t'(32'hf000 - k * 32'h0101);
        M_EQUAL: pkt[k] = 16'h5a5a;
        default: pkt[k] = const_w[k];
      endcase
    end
  endtask

  // Plain bubble sort of the words that fit into the buffer
  task sort_expected(input int n);
    int         a;
    int         b;
    qs_pkg::w_t tmp;
    for (a = 0; a < n; a++) begin
      exp_w[a] = pkt[a];
    end
    for (a = 0; a < n - 1; a++) begin
      for (b = 0; b < n - 1 - a; b++) begin
        if (exp_w[b] > exp_w[b + 1]) begin
          tmp          = exp_w[b];
          exp_w[b]     = exp_w[b + 1];
          exp_w[b + 1] = tmp;
        end
      end
    end
  endtask

  // Called on a falling edge, returns on the falling edge where in_rdy is high
  task wait_ready(input string name);
    int n;
    n = 0;
    while (!in_rdy && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    assert (in_rdy) else begin
      $display("%s: in_rdy stayed low for %0d cycles", name, TIMEOUT);
      err_cnt++;
      hung = 1'b1;
    end
  endtask

  // Beats with no open packet, one of them carrying eop, must be dropped
  task send_stray(input string name);
    wait_ready(name);
    if (!hung) begin
      in_vld = 1'b1;
      in_sop = 1'b0;
      in_eop = 1'b0;
      in_dat = 16'hdead;
      @(negedge clk);
      in_eop = 1'b1;
      in_dat = 16'h0bad;
      @(negedge clk);
      in_vld = 1'b0;
      in_eop = 1'b0;
      @(negedge clk);
      // A stray eop closes no packet, so the input stays open
      check_value(name, "in_rdy after stray beats", 1, int'(in_rdy));
    end
  endtask

  task send_packet(input string name, input int len, input bit gap);
    int k;
    for (k = 0; k < len && !hung; k++) begin
      // An idle cycle between beats when gaps are asked for
      if (gap && k > 0) begin
        in_vld = 1'b0;
        in_sop = 1'b0;
        in_eop = 1'b0;
        @(negedge clk);
      end
      wait_ready(name);
      if (!hung) begin
        in_vld = 1'b1;
        in_sop = (k == 0);
        in_eop = (k == len - 1);
        in_dat = pkt[k];
        @(negedge clk);
      end
    end
    in_vld = 1'b0;
    in_sop = 1'b0;
    in_eop = 1'b0;
  endtask

  task collect_output(input string name, input int n, input bit err);
    int wt;
    int b;
    wt = 0;
    // The engine holds one packet, so in_rdy stays low until the output ends
    while (!out_vld_r && wt < TIMEOUT) begin
      check_value(name, "in_rdy before output", 0, int'(in_rdy));
      @(negedge clk);
      wt++;
    end
    assert (out_vld_r) else begin
      $display("%s: no output beat within %0d cycles", name, TIMEOUT);
      err_cnt++;
      hung = 1'b1;
    end
    for (b = 0; b < n && !hung; b++) begin
      check_value(name, $sformatf("out_vld_r beat %0d", b), 1, int'(out_vld_r));
      check_value(name, $sformatf("out_dat_r beat %0d", b), int'(exp_w[b]), int'(out_dat_r));
      check_value(name, $sformatf("out_sop_r beat %0d", b), int'(b == 0), int'(out_sop_r));
      check_value(name, $sformatf("out_eop_r beat %0d", b), int'(b == n - 1), int'(out_eop_r));
      check_value(name, $sformatf("out_err_r beat %0d", b), int'(err), int'(out_err_r));
      check_value(name, $sformatf("in_rdy beat %0d", b), 0, int'(in_rdy));
      @(negedge clk);
    end
    if (!hung) begin
      // No extra beat, and the input opens again one cycle after eop
      check_value(name, "out_vld_r after eop", 0, int'(out_vld_r));
      check_value(name, "in_rdy after eop", 1, int'(in_rdy));
    end
  endtask

  initial begin
    int t;
    int n_exp;
    int errs_before;
    int run;
    int passed;
    clk     = 1'b0;
    arst_n  = 1'b0;
    in_vld  = 1'b0;
    in_sop  = 1'b0;
    in_eop  = 1'b0;
    in_dat  = '0;
    lfsr_q  = 32'h9a72_650c;
    err_cnt = 0;
    hung    = 1'b0;
    run     = 0;
    passed  = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    for (t = 0; t < NT && !hung; t++) begin
      errs_before = err_cnt;
      n_exp = (t_len[t] > qs_pkg::N) ? qs_pkg::N : t_len[t];
      build_packet(t);
      sort_expected(n_exp);
      if (t_gap[t]) begin
        send_stray(t_name[t]);
      end
      send_packet(t_name[t], t_len[t], t_gap[t]);
      if (!hung) begin
        collect_output(t_name[t], n_exp, t_len[t] > qs_pkg::N);
      end
      run++;
      if (err_cnt == errs_before) begin
        passed++;
        $display("test %-16s ok, %0d words", t_name[t], n_exp);
      end else begin
        $display("test %-16s bad, %0d errors", t_name[t], err_cnt - errs_before);
      end
    end
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             run, passed, run - passed, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
